/* logic/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`default_nettype none

// machine word width in bits
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`default_nettype wire

`endif

/* logic/rv_pkg.sv */
`include "rv_settings.svh"
`default_nettype none

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;

  // one bit per byte lane of a data word
  typedef logic [3:0] sel_t;

  // rv32i major opcodes in encoding order
  typedef enum logic [6:0] {
    op_load     = 7'b0000011,
    op_misc_mem = 7'b0001111,
    op_imm      = 7'b0010011,
    op_auipc    = 7'b0010111,
    op_store    = 7'b0100011,
    op_reg      = 7'b0110011,
    op_lui      = 7'b0110111,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_jal      = 7'b1101111,
    op_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b, alu_add_pc
  } alu_op_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu, mem_sb, mem_sh, mem_sw
  } mem_op_e;

  // jumps are folded in with the conditional branches
  typedef enum logic [3:0] {
    br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jal, br_jalr, br_none
  } br_e;

endpackage

`default_nettype wire

/* logic/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  input  logic          retire,
  input  rv_pkg::word_t next_pc,
  input  logic          halt,
  output logic          ibus_cyc,
  output logic          ibus_stb,
  output rv_pkg::word_t ibus_adr,
  input  rv_pkg::word_t ibus_dat_r,
  input  logic          ibus_ack,
  output logic          insn_valid,
  output rv_pkg::word_t insn,
  output rv_pkg::word_t insn_pc
);

  typedef enum logic [1:0] {
    st_idle,
    st_bus,
    st_wait
  } state_e;

  state_e        state;
  rv_pkg::word_t pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      pc         <= `RV_RESET_PC;
      insn_valid <= 1'b0;
    end else begin
      insn_valid <= 1'b0;
      case (state)
        // leaves right after reset, and is the parking state once halted
        st_idle: begin
          if (!halt) begin
            state <= st_bus;
          end
        end
        st_bus: begin
          if (ibus_ack) begin
            insn_valid <= 1'b1;
            state      <= st_wait;
          end
        end
        // one instruction in flight, hold until the back end retires it
        st_wait: begin
          if (retire) begin
            pc    <= next_pc;
            state <= halt ? st_idle : st_bus;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_bus && ibus_ack) begin
      insn    <= ibus_dat_r;
      insn_pc <= pc;
    end
  end

  assign ibus_cyc = (state == st_bus);
  assign ibus_stb = (state == st_bus);
  assign ibus_adr = pc;

  // a bad jump target must never reach the instruction bus
  a_ibus_aligned: assert property (@(posedge clk) disable iff (rst)
    ibus_stb |-> ibus_adr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"
`default_nettype none

module rv_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_valid,
  input  rv_pkg::word_t     insn,
  input  rv_pkg::word_t     insn_pc,
  input  logic              wb_en,
  input  rv_pkg::reg_idx_t  wb_rd,
  input  rv_pkg::word_t     wb_data,
  output logic              dec_valid,
  output rv_pkg::word_t     dec_pc,
  output rv_pkg::word_t     dec_rs1_val,
  output rv_pkg::word_t     dec_rs2_val,
  output rv_pkg::word_t     dec_imm,
  output rv_pkg::reg_idx_t  dec_rd,
  output rv_pkg::alu_op_e   dec_alu_op,
  output logic              dec_use_imm,
  output rv_pkg::br_e       dec_br,
  output rv_pkg::mem_op_e   dec_mem_op,
  output logic              dec_wen,
  output logic              dec_ecall
);

  rv_pkg::opcode_e  opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm_i, imm_s, imm_b, imm_j, imm_u;
  rv_pkg::word_t    imm;
  rv_pkg::alu_op_e  alu_op;
  logic             use_imm;
  rv_pkg::br_e      br;
  rv_pkg::mem_op_e  mem_op;
  logic             wen;
  logic             ecall;
  rv_pkg::word_t    regs [`RV_NUM_REGS];

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign rd     = insn[11:7];

  // all immediates are sign extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // alt is funct7 bit 5, selecting sub and sra
  function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_from_funct = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  alu_from_funct = rv_pkg::alu_sll;
      3'b010:  alu_from_funct = rv_pkg::alu_slt;
      3'b011:  alu_from_funct = rv_pkg::alu_sltu;
      3'b100:  alu_from_funct = rv_pkg::alu_xor;
      3'b101:  alu_from_funct = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  alu_from_funct = rv_pkg::alu_or;
      default: alu_from_funct = rv_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    imm     = imm_i;
    alu_op  = rv_pkg::alu_add;
    use_imm = 1'b0;
    br      = rv_pkg::br_none;
    mem_op  = rv_pkg::mem_none;
    wen     = 1'b0;
    ecall   = 1'b0;
    case (opcode)
      rv_pkg::op_lui, rv_pkg::op_auipc: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = (opcode == rv_pkg::op_lui) ? rv_pkg::alu_pass_b : rv_pkg::alu_add_pc;
        wen     = 1'b1;
      end
      rv_pkg::op_jal: begin
        imm = imm_j;
        br  = rv_pkg::br_jal;
        wen = 1'b1;
      end
      rv_pkg::op_jalr: begin
        br  = rv_pkg::br_jalr;
        wen = 1'b1;
      end
      rv_pkg::op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000:  br = rv_pkg::br_beq;
          3'b001:  br = rv_pkg::br_bne;
          3'b100:  br = rv_pkg::br_blt;
          3'b101:  br = rv_pkg::br_bge;
          3'b110:  br = rv_pkg::br_bltu;
          3'b111:  br = rv_pkg::br_bgeu;
          default: br = rv_pkg::br_none;
        endcase
      end
      rv_pkg::op_load: begin
        wen = 1'b1;
        case (funct3)
          3'b000:  mem_op = rv_pkg::mem_lb;
          3'b001:  mem_op = rv_pkg::mem_lh;
          3'b010:  mem_op = rv_pkg::mem_lw;
          3'b100:  mem_op = rv_pkg::mem_lbu;
          3'b101:  mem_op = rv_pkg::mem_lhu;
          default: wen = 1'b0;
        endcase
      end
      rv_pkg::op_store: begin
        imm = imm_s;
        case (funct3)
          3'b000:  mem_op = rv_pkg::mem_sb;
          3'b001:  mem_op = rv_pkg::mem_sh;
          3'b010:  mem_op = rv_pkg::mem_sw;
          default: mem_op = rv_pkg::mem_none;
        endcase
      end
      rv_pkg::op_imm: begin
        use_imm = 1'b1;
        alu_op  = alu_from_funct(funct3, funct7[5] && funct3 == 3'b101);
        wen     = 1'b1;
      end
      rv_pkg::op_reg: begin
        alu_op = alu_from_funct(funct3, funct7[5]);
        // M extension and other funct7 values fall through as a nop
        wen    = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
      end
      rv_pkg::op_system: ecall = (insn[31:7] == 25'd0);
      // fence and unknown opcodes retire with no effect
      default: wen = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= insn_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (insn_valid) begin
      dec_pc      <= insn_pc;
      dec_rs1_val <= (rs1 == '0) ? '0 : regs[rs1];
      dec_rs2_val <= (rs2 == '0) ? '0 : regs[rs2];
      dec_imm     <= imm;
      dec_rd      <= rd;
      dec_alu_op  <= alu_op;
      dec_use_imm <= use_imm;
      dec_br      <= br;
      dec_mem_op  <= mem_op;
      dec_wen     <= wen;
      dec_ecall   <= ecall;
    end
  end

  // writeback must land before the next instruction reads its operands
  a_wb_not_with_insn: assert property (@(posedge clk) disable iff (rst)
    !(wb_en && insn_valid));

endmodule

`default_nettype wire

/* logic/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  logic              clk,
  input  logic              rst,
  input  logic              dec_valid,
  input  rv_pkg::word_t     dec_pc,
  input  rv_pkg::word_t     dec_rs1_val,
  input  rv_pkg::word_t     dec_rs2_val,
  input  rv_pkg::word_t     dec_imm,
  input  rv_pkg::reg_idx_t  dec_rd,
  input  rv_pkg::alu_op_e   dec_alu_op,
  input  logic              dec_use_imm,
  input  rv_pkg::br_e       dec_br,
  input  rv_pkg::mem_op_e   dec_mem_op,
  input  logic              dec_wen,
  input  logic              dec_ecall,
  output logic              ex_valid,
  output rv_pkg::word_t     ex_result,
  output rv_pkg::word_t     ex_addr,
  output rv_pkg::word_t     ex_store_data,
  output rv_pkg::word_t     ex_next_pc,
  output rv_pkg::reg_idx_t  ex_rd,
  output rv_pkg::mem_op_e   ex_mem_op,
  output logic              ex_wen,
  output logic              ex_ecall
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_res;
  rv_pkg::word_t addr;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t next_pc;
  logic          taken;
  logic          is_jump;

  assign op_a     = dec_rs1_val;
  assign op_b     = dec_use_imm ? dec_imm : dec_rs2_val;
  assign addr     = dec_rs1_val + dec_imm;
  assign pc_plus4 = dec_pc + 32'd4;
  assign is_jump  = (dec_br == rv_pkg::br_jal) || (dec_br == rv_pkg::br_jalr);

  always_comb begin
    case (dec_alu_op)
      rv_pkg::alu_sub:    alu_res = op_a - op_b;
      rv_pkg::alu_sll:    alu_res = op_a << op_b[4:0];
      rv_pkg::alu_slt:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu:   alu_res = {31'd0, op_a < op_b};
      rv_pkg::alu_xor:    alu_res = op_a ^ op_b;
      rv_pkg::alu_srl:    alu_res = op_a >> op_b[4:0];
      rv_pkg::alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
      rv_pkg::alu_or:     alu_res = op_a | op_b;
      rv_pkg::alu_and:    alu_res = op_a & op_b;
      rv_pkg::alu_pass_b: alu_res = op_b;
      rv_pkg::alu_add_pc: alu_res = dec_pc + op_b;
      default:            alu_res = op_a + op_b;
    endcase
  end

  // branches always compare the two registers, never the immediate
  always_comb begin
    case (dec_br)
      rv_pkg::br_beq:  taken = dec_rs1_val == dec_rs2_val;
      rv_pkg::br_bne:  taken = dec_rs1_val != dec_rs2_val;
      rv_pkg::br_blt:  taken = $signed(dec_rs1_val) < $signed(dec_rs2_val);
      rv_pkg::br_bge:  taken = $signed(dec_rs1_val) >= $signed(dec_rs2_val);
      rv_pkg::br_bltu: taken = dec_rs1_val < dec_rs2_val;
      rv_pkg::br_bgeu: taken = dec_rs1_val >= dec_rs2_val;
      rv_pkg::br_jal:  taken = 1'b1;
      default:         taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec_br == rv_pkg::br_jalr) begin
      next_pc = {addr[31:1], 1'b0};
    end else if (taken) begin
      next_pc = dec_pc + dec_imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      // jumps write the link address
      ex_result     <= is_jump ? pc_plus4 : alu_res;
      ex_addr       <= addr;
      ex_store_data <= dec_rs2_val;
      ex_next_pc    <= next_pc;
      ex_rd         <= dec_rd;
      ex_mem_op     <= dec_mem_op;
      ex_wen        <= dec_wen;
      ex_ecall      <= dec_ecall;
    end
  end

endmodule

`default_nettype wire

/* logic/rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memory (
  input  logic              clk,
  input  logic              rst,
  input  logic              ex_valid,
  input  rv_pkg::word_t     ex_result,
  input  rv_pkg::word_t     ex_addr,
  input  rv_pkg::word_t     ex_store_data,
  input  rv_pkg::word_t     ex_next_pc,
  input  rv_pkg::reg_idx_t  ex_rd,
  input  rv_pkg::mem_op_e   ex_mem_op,
  input  logic              ex_wen,
  input  logic              ex_ecall,
  output logic              dbus_cyc,
  output logic              dbus_stb,
  output logic              dbus_we,
  output rv_pkg::word_t     dbus_adr,
  output rv_pkg::word_t     dbus_dat_w,
  output rv_pkg::sel_t      dbus_sel,
  input  rv_pkg::word_t     dbus_dat_r,
  input  logic              dbus_ack,
  output logic              wb_en,
  output rv_pkg::reg_idx_t  wb_rd,
  output rv_pkg::word_t     wb_data,
  output logic              retire,
  output rv_pkg::word_t     next_pc,
  output logic              halt
);

  typedef enum logic {
    st_idle,
    st_bus
  } state_e;

  state_e          state;
  rv_pkg::mem_op_e op_q;
  logic [1:0]      lane_q;
  logic            wen_q;
  logic            is_store;
  rv_pkg::sel_t    store_sel;
  rv_pkg::word_t   store_data;
  rv_pkg::word_t   lane_data;
  rv_pkg::word_t   load_val;

  assign is_store = ex_mem_op inside {rv_pkg::mem_sb, rv_pkg::mem_sh, rv_pkg::mem_sw};

  // narrow stores are replicated so any selected lane holds the value
  always_comb begin
    case (ex_mem_op)
      rv_pkg::mem_sb: begin
        store_sel  = 4'b0001 << ex_addr[1:0];
        store_data = {4{ex_store_data[7:0]}};
      end
      rv_pkg::mem_sh: begin
        store_sel  = ex_addr[1] ? 4'b1100 : 4'b0011;
        store_data = {2{ex_store_data[15:0]}};
      end
      default: begin
        store_sel  = 4'b1111;
        store_data = ex_store_data;
      end
    endcase
  end

  // move the addressed lane down to bit 0 before extending
  assign lane_data = dbus_dat_r >> {lane_q, 3'b000};

  always_comb begin
    case (op_q)
      rv_pkg::mem_lb:  load_val = {{24{lane_data[7]}}, lane_data[7:0]};
      rv_pkg::mem_lbu: load_val = {24'd0, lane_data[7:0]};
      rv_pkg::mem_lh:  load_val = {{16{lane_data[15]}}, lane_data[15:0]};
      rv_pkg::mem_lhu: load_val = {16'd0, lane_data[15:0]};
      default:         load_val = dbus_dat_r;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      dbus_we <= 1'b0;
      wb_en   <= 1'b0;
      retire  <= 1'b0;
      halt    <= 1'b0;
    end else begin
      wb_en  <= 1'b0;
      retire <= 1'b0;
      if (state == st_idle && ex_valid) begin
        if (ex_mem_op == rv_pkg::mem_none) begin
          wb_en  <= ex_wen;
          retire <= 1'b1;
          // halt rises with the ecall retire so fetch sees it on that edge
          if (ex_ecall) begin
            halt <= 1'b1;
          end
        end else begin
          state   <= st_bus;
          dbus_we <= is_store;
        end
      end else if (state == st_bus && dbus_ack) begin
        state   <= st_idle;
        dbus_we <= 1'b0;
        wb_en   <= wen_q;
        retire  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && ex_valid) begin
      wb_rd      <= ex_rd;
      wb_data    <= ex_result;
      next_pc    <= ex_next_pc;
      op_q       <= ex_mem_op;
      lane_q     <= ex_addr[1:0];
      wen_q      <= ex_wen;
      dbus_adr   <= {ex_addr[31:2], 2'b00};
      dbus_sel   <= store_sel;
      dbus_dat_w <= store_data;
    end else if (state == st_bus && dbus_ack) begin
      wb_data <= load_val;
    end
  end

  assign dbus_cyc = (state == st_bus);
  assign dbus_stb = (state == st_bus);

  // store lanes come from decode and address alike, none may drop out
  a_write_has_lanes: assert property (@(posedge clk) disable iff (rst)
    (dbus_stb && dbus_we) |-> dbus_sel != 4'b0000);

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output logic          halt,
  output logic          ibus_cyc,
  output logic          ibus_stb,
  output rv_pkg::word_t ibus_adr,
  input  rv_pkg::word_t ibus_dat_r,
  input  logic          ibus_ack,
  output logic          dbus_cyc,
  output logic          dbus_stb,
  output logic          dbus_we,
  output rv_pkg::word_t dbus_adr,
  output rv_pkg::sel_t  dbus_sel,
  output rv_pkg::word_t dbus_dat_w,
  input  rv_pkg::word_t dbus_dat_r,
  input  logic          dbus_ack
);

  // fetch to decode
  logic             insn_valid;
  rv_pkg::word_t    insn, insn_pc;

  // decode to execute
  logic             dec_valid, dec_use_imm, dec_wen, dec_ecall;
  rv_pkg::word_t    dec_pc, dec_rs1_val, dec_rs2_val, dec_imm;
  rv_pkg::reg_idx_t dec_rd;
  rv_pkg::alu_op_e  dec_alu_op;
  rv_pkg::br_e      dec_br;
  rv_pkg::mem_op_e  dec_mem_op;

  // execute to memory
  logic             ex_valid, ex_wen, ex_ecall;
  rv_pkg::word_t    ex_result, ex_addr, ex_store_data, ex_next_pc;
  rv_pkg::reg_idx_t ex_rd;
  rv_pkg::mem_op_e  ex_mem_op;

  // writeback and retire, back to decode and fetch
  logic             wb_en, retire;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::word_t    wb_data, next_pc;

  rv_fetch u_fetch (
    .clk, .rst, .retire, .next_pc, .halt,
    .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_dat_r, .ibus_ack,
    .insn_valid, .insn, .insn_pc
  );

  rv_decode u_decode (
    .clk, .rst, .insn_valid, .insn, .insn_pc, .wb_en, .wb_rd, .wb_data,
    .dec_valid, .dec_pc, .dec_rs1_val, .dec_rs2_val, .dec_imm, .dec_rd,
    .dec_alu_op, .dec_use_imm, .dec_br, .dec_mem_op, .dec_wen, .dec_ecall
  );

  rv_execute u_execute (
    .clk, .rst, .dec_valid, .dec_pc, .dec_rs1_val, .dec_rs2_val, .dec_imm, .dec_rd,
    .dec_alu_op, .dec_use_imm, .dec_br, .dec_mem_op, .dec_wen, .dec_ecall,
    .ex_valid, .ex_result, .ex_addr, .ex_store_data, .ex_next_pc, .ex_rd,
    .ex_mem_op, .ex_wen, .ex_ecall
  );

  rv_memory u_memory (
    .clk, .rst, .ex_valid, .ex_result, .ex_addr, .ex_store_data, .ex_next_pc,
    .ex_rd, .ex_mem_op, .ex_wen, .ex_ecall,
    .dbus_cyc, .dbus_stb, .dbus_we, .dbus_adr, .dbus_dat_w, .dbus_sel,
    .dbus_dat_r, .dbus_ack,
    .wb_en, .wb_rd, .wb_data, .retire, .next_pc, .halt
  );

endmodule

`default_nettype wire

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int MEM_WORDS = 256;
  // expected store list starts at this word of the data file
  localparam int EXP_BASE  = 256;
  localparam int MAX_WAIT  = 3;

  logic             clk;
  logic             rst;
  logic             halt;
  logic             ibus_cyc, ibus_stb, ibus_ack;
  rv_pkg::word_t    ibus_adr, ibus_dat_r;
  logic             dbus_cyc, dbus_stb, dbus_we, dbus_ack;
  rv_pkg::word_t    dbus_adr, dbus_dat_w, dbus_dat_r;
  rv_pkg::sel_t     dbus_sel;

  rv_pkg::word_t    td [0:511];
  rv_pkg::word_t    mem [0:MEM_WORDS-1];
  int               exp_count;
  int               store_idx;
  int               prog_words;
  int               cycle_limit;
  int               cycles;

  rv_core u_dut (
    .clk, .rst, .halt,
    .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_dat_r, .ibus_ack,
    .dbus_cyc, .dbus_stb, .dbus_we, .dbus_adr, .dbus_sel, .dbus_dat_w,
    .dbus_dat_r, .dbus_ack
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t got,
                            input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("mismatch %s at store %0d: got %h expected %h", name, store_idx, got, exp);
      fail_run("wrong value on the data bus");
    end
  endtask

  task automatic check_sel(input string name, input rv_pkg::sel_t got,
                           input rv_pkg::sel_t exp);
    if (got !== exp) begin
      $display("mismatch %s at store %0d: got %h expected %h", name, store_idx, got, exp);
      fail_run("wrong lane select on the data bus");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s at cycle %0d: got %h expected %h", name, cycles, got, exp);
      fail_run("bus control or halt output out of step");
    end
  endtask

  // ack comes 0 to MAX_WAIT cycles late
  task automatic random_wait();
    int n;
    n = $urandom % (MAX_WAIT + 1);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_range(input string bus, input rv_pkg::word_t adr);
    if (adr >= MEM_WORDS * 4) begin
      fail_run($sformatf("%s address %h is outside the memory model", bus, adr));
    end
  endtask

  task automatic check_store();
    int base;
    base = EXP_BASE + 1 + 3 * store_idx;
    if (store_idx >= exp_count) begin
      fail_run("the core issued more stores than the expected list holds");
    end
    check_word("dbus_adr", dbus_adr, td[base]);
    check_word("dbus_dat_w", dbus_dat_w, td[base+1]);
    check_sel("dbus_sel", dbus_sel, rv_pkg::sel_t'(td[base+2][3:0]));
    store_idx++;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // instruction side of the memory model
  initial begin
    ibus_ack   = 1'b0;
    ibus_dat_r = '0;
    forever begin
      @(posedge clk);
      #1;
      if (!rst && ibus_stb) begin
        // cyc rises with stb and both stay up until ack
        check_bit("ibus_cyc", ibus_cyc, 1'b1);
        random_wait();
        check_bit("ibus_cyc", ibus_cyc, 1'b1);
        check_bit("ibus_stb", ibus_stb, 1'b1);
        check_range("ibus", ibus_adr);
        ibus_dat_r = mem[ibus_adr[9:2]];
        ibus_ack   = 1'b1;
        @(posedge clk);
        #1;
        ibus_ack = 1'b0;
        // both drop in the cycle after ack
        check_bit("ibus_cyc", ibus_cyc, 1'b0);
        check_bit("ibus_stb", ibus_stb, 1'b0);
      end else if (!rst) begin
        check_bit("ibus_cyc", ibus_cyc, 1'b0);
      end
    end
  end

  // data side, writes land lane by lane
  initial begin
    dbus_ack   = 1'b0;
    dbus_dat_r = '0;
    forever begin
      @(posedge clk);
      #1;
      if (!rst && dbus_stb) begin
        check_bit("dbus_cyc", dbus_cyc, 1'b1);
        random_wait();
        check_bit("dbus_cyc", dbus_cyc, 1'b1);
        check_bit("dbus_stb", dbus_stb, 1'b1);
        check_range("dbus", dbus_adr);
        if (dbus_we) begin
          check_store();
          for (int b = 0; b < 4; b++) begin
            if (dbus_sel[b]) begin
              mem[dbus_adr[9:2]][8*b +: 8] = dbus_dat_w[8*b +: 8];
            end
          end
        end else begin
          dbus_dat_r = mem[dbus_adr[9:2]];
        end
        dbus_ack = 1'b1;
        @(posedge clk);
        #1;
        dbus_ack = 1'b0;
        check_bit("dbus_cyc", dbus_cyc, 1'b0);
        check_bit("dbus_stb", dbus_stb, 1'b0);
      end else if (!rst) begin
        check_bit("dbus_cyc", dbus_cyc, 1'b0);
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
        fail_run($sformatf("timeout: the core did not halt within %0d cycles", cycle_limit));
      end
    end
  end

  initial begin
    void'($urandom(32'h6fc1));
    rst         = 1'b1;
    store_idx   = 0;
    prog_words  = 0;
    cycle_limit = 0;
    for (int i = 0; i < 512; i++) begin
      td[i] = '0;
    end
    $readmemh("tb/rv_testdata.hex", td);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = td[i];
      if (td[i] != '0) begin
        prog_words++;
      end
    end
    exp_count = int'(td[EXP_BASE]);
    // roughly eight bus-bound cycles per instruction at the longest wait
    cycle_limit = prog_words * 8 * (MAX_WAIT + 1) + 200;
    if (exp_count == 0) begin
      fail_run("the data file holds no expected stores");
    end

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    while (halt !== 1'b1) begin
      @(posedge clk);
      #1;
    end

    repeat (50) begin
      @(posedge clk);
      #1;
      check_bit("halt", halt, 1'b1);
      if (ibus_stb || dbus_stb) begin
        fail_run("a bus cycle started after halt");
      end
    end

    if (store_idx == exp_count) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("the core issued %0d stores, the list expects %0d", store_idx, exp_count);
      $display("Test failed");
      $fatal(1, "store count differs");
    end
  end

endmodule

`default_nettype wire

/* tb/rv_testdata.hex */
// words from @000: program image, one or more instructions per line
// words from @100: expected store count, then address data select per store
@000
20000513 FF900093 00300113 // x10=0x200 x1=-7 x2=3
002082B3 00552023 // add
402082B3 00552223 // sub
002092B3 00552423 // sll
0020A2B3 00552623 // slt
0020B2B3 00552823 // sltu
0020C2B3 00552A23 // xor
0020D2B3 00552C23 // srl
4020D2B3 00552E23 // sra
0020E2B3 02552023 // or
0020F2B3 02552223 // and
12308293 02552423 // addi 0x123
00409293 02552623 // slli 4
FF80A293 02552823 // slti -8
FFF0B293 02552A23 // sltiu -1
0F00C293 02552C23 // xori 0x0f0
01C0D293 02552E23 // srli 28
4010D293 04552023 // srai 1
0060E293 04552223 // ori 6
7F00F293 04552423 // andi 0x7f0
02000293 00108463 10028293 04552623 // beq taken
02100293 00208463 10028293 04552823 // beq not taken
02200293 00209463 10028293 04552A23 // bne taken
02300293 00109463 10028293 04552C23 // bne not taken
02400293 0020C463 10028293 04552E23 // blt taken
02500293 00114463 10028293 06552023 // blt not taken
02600293 00115463 10028293 06552223 // bge taken
02700293 0020D463 10028293 06552423 // bge not taken
02800293 00116463 10028293 06552623 // bltu taken
02900293 0020E463 10028293 06552823 // bltu not taken
02A00293 0020F463 10028293 06552A23 // bgeu taken
02B00293 00117463 10028293 06552C23 // bgeu not taken
0080036F 00000313 06652E23 // jal x6 at 0x164, store link
00000397 00C38467 00000413 08852023 // auipc x7, jalr x8 at 0x174, store link
123452B7 08552223 00001297 08552423 // lui, auipc at 0x188
A1B2C5B7 3D458593 // x11 = 0xa1b2c3d4
08B50623 08B506A3 08B50723 08B507A3 // sb at offsets 0 to 3
08B51823 08B51923 08B52A23 // sh at 0 and 2, sw
09550283 08552C23 // lb 0x295
09554283 08552E23 // lbu 0x295
09651283 0A552023 // lh 0x296
09655283 0A552223 // lhu 0x296
09452283 0A552423 // lw 0x294
00000073 // ecall
@100
0000002F
00000200 FFFFFFFC 0000000F
00000204 FFFFFFF6 0000000F
00000208 FFFFFFC8 0000000F
0000020C 00000001 0000000F
00000210 00000000 0000000F
00000214 FFFFFFFA 0000000F
00000218 1FFFFFFF 0000000F
0000021C FFFFFFFF 0000000F
00000220 FFFFFFFB 0000000F
00000224 00000001 0000000F
00000228 0000011C 0000000F
0000022C FFFFFF90 0000000F
00000230 00000000 0000000F
00000234 00000001 0000000F
00000238 FFFFFF09 0000000F
0000023C 0000000F 0000000F
00000240 FFFFFFFC 0000000F
00000244 FFFFFFFF 0000000F
00000248 000007F0 0000000F
0000024C 00000020 0000000F
00000250 00000121 0000000F
00000254 00000022 0000000F
00000258 00000123 0000000F
0000025C 00000024 0000000F
00000260 00000125 0000000F
00000264 00000026 0000000F
00000268 00000127 0000000F
0000026C 00000028 0000000F
00000270 00000129 0000000F
00000274 0000002A 0000000F
00000278 0000012B 0000000F
0000027C 00000168 0000000F
00000280 00000178 0000000F
00000284 12345000 0000000F
00000288 00001188 0000000F
0000028C D4D4D4D4 00000001
0000028C D4D4D4D4 00000002
0000028C D4D4D4D4 00000004
0000028C D4D4D4D4 00000008
00000290 C3D4C3D4 00000003
00000290 C3D4C3D4 0000000C
00000294 A1B2C3D4 0000000F
00000298 FFFFFFC3 0000000F
0000029C 000000C3 0000000F
000002A0 FFFFA1B2 0000000F
000002A4 0000A1B2 0000000F
000002A8 A1B2C3D4 0000000F

/* project.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_memory.sv
logic/rv_core.sv
tb/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim
